/* hw/cmd_pkg.sv */
package cmd_pkg;

	// ----------------------------------------------------------------------
	// pipe word geometry
	// ----------------------------------------------------------------------
	localparam int WORD_W    = 32;  // host pipe word
	localparam int CMD_WORDS = 4;   // pipe words per layer command

	// layer opcodes, 4 to 7 are illegal
	typedef enum logic [2:0] {
		OP_CONV3X3 = 3'd0,
		OP_CONV1X1 = 3'd1,
		OP_MAXPOOL = 3'd2,
		OP_AVEPOOL = 3'd3
	} op_e;

	// command parser states
	typedef enum logic [1:0] {
		ST_IDLE,     // parsing disabled
		ST_COLLECT,  // popping command words
		ST_ISSUE,    // strobe command to engine
		ST_WAIT      // engine busy
	} parse_state_e;

	// ----------------------------------------------------------------------
	// decoded command
	// Field order follows the words from word 3 down to word 0, so the
	// struct lines up with the concatenation of the raw words.
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic [31:0] weight_addr;  // word 3
		logic [31:0] data_addr;    // word 2
		logic [15:0] o_channel;    // word 1 high half
		logic [15:0] i_channel;    // word 1 low half
		logic [7:0]  o_side;       // word 0 [31:24]
		logic [7:0]  i_side;       // word 0 [23:16]
		logic [7:0]  kernel;       // word 0 [15:8]
		logic [3:0]  stride;       // word 0 [7:4]
		logic        padding;      // word 0 [3]
		op_e         op;           // word 0 [2:0]
	} cmd_t;

endpackage

/* hw/pipe_in_gate.sv */
`timescale 1ns/1ns

module pipe_in_gate
	import cmd_pkg::*;
#(
	parameter int DEPTH       = 64,
	parameter int BLOCK_WORDS = 16,
	parameter int HEADROOM    = 4
) (
	input  logic                            okClk,
	input  logic                            i_arst_n,
	input  logic                            i_pipe_write,
	input  logic [WORD_W-1:0]               i_pipe_data,
	input  logic [$clog2(DEPTH):0]          i_fifo_count,
	input  logic                            i_fifo_full,
	output logic                            o_wr_en,
	output logic [WORD_W-1:0]               o_wr_data,
	output logic                            o_pipe_ready,
	output logic                            o_overrun
);

	localparam int CNT_W  = $clog2(DEPTH) + 1;
	// room for one more block less the margin for count latency
	localparam int THRESH = DEPTH - HEADROOM - BLOCK_WORDS;

	logic [CNT_W-1:0] count_q;

	assign count_q   = i_fifo_count;
	assign o_wr_en   = i_pipe_write & ~i_fifo_full;  // drop writes into a full FIFO
	assign o_wr_data = i_pipe_data;

	// registered block throttle
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_pipe_ready <= 1'b0;
			o_overrun    <= 1'b0;
		end else begin
			o_pipe_ready <= (int'(count_q) <= THRESH);
			if (i_pipe_write && i_fifo_full)
				o_overrun <= 1'b1;  // sticky until reset
		end
	end

	// ready high promises room for a whole block
	a_ready_room : assert property (
		@(posedge okClk) disable iff (!i_arst_n)
		o_pipe_ready |-> (int'(count_q) <= DEPTH - BLOCK_WORDS)
	);

endmodule

/* hw/word_fifo.sv */
`timescale 1ns/1ns

module word_fifo
	import cmd_pkg::*;
#(
	parameter int DEPTH = 64
) (
	input  logic                   okClk,
	input  logic                   i_arst_n,
	input  logic                   i_wr_en,
	input  logic [WORD_W-1:0]      i_wr_data,
	input  logic                   i_rd_en,
	output logic [WORD_W-1:0]      o_rd_data,
	output logic                   o_empty,
	output logic                   o_full,
	output logic [$clog2(DEPTH):0] o_count
);

	localparam int AW    = $clog2(DEPTH);
	localparam int CNT_W = AW + 1;

	logic [WORD_W-1:0] mem [DEPTH];
	logic [AW-1:0]     wr_ptr;
	logic [AW-1:0]     rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              wr_ok;
	logic              rd_ok;

	assign wr_ok = i_wr_en & ~o_full;
	assign rd_ok = i_rd_en & ~o_empty;

	assign o_empty   = (count == '0);
	assign o_full    = (count == CNT_W'(DEPTH));
	assign o_count   = count;
	assign o_rd_data = mem[rd_ptr];  // head word shown ahead

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (wr_ok)
			mem[wr_ptr] <= i_wr_data;
	end

	// ----------------------------------------------------------------------
	// pointers and occupancy
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or simultaneous push and pop
			endcase
		end
	end

	// producer and consumer both promise to respect the flags
	a_no_write_full : assert property (
		@(posedge okClk) disable iff (!i_arst_n)
		i_wr_en |-> !o_full
	);

	a_no_read_empty : assert property (
		@(posedge okClk) disable iff (!i_arst_n)
		i_rd_en |-> !o_empty
	);

endmodule

/* hw/cmd_parser.sv */
`timescale 1ns/1ns

module cmd_parser
	import cmd_pkg::*;
(
	input  logic              okClk,
	input  logic              i_arst_n,
	input  logic              i_op_en,
	input  logic [7:0]        i_cmd_count,
	input  logic [WORD_W-1:0] i_rd_data,
	input  logic              i_empty,
	input  logic              i_engine_done,
	output logic              o_rd_en,
	output cmd_t              o_cmd,
	output logic              o_cmd_valid,
	output logic              o_irq
);

	localparam int IDX_W = $clog2(CMD_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(CMD_WORDS - 1);

	parse_state_e      state;
	logic [IDX_W-1:0]  word_idx;
	logic [WORD_W-1:0] cmd_words [CMD_WORDS];
	logic [7:0]        done_cnt;

	// pop one word per cycle while collecting
	assign o_rd_en = (state == ST_COLLECT) & i_op_en & ~i_empty;

	// ----------------------------------------------------------------------
	// command FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state       <= ST_IDLE;
			word_idx    <= '0;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_op_en)
						state <= ST_COLLECT;
				end
				ST_COLLECT: begin
					if (!i_op_en) begin
						state <= ST_IDLE;  // partial command is kept
					end else if (!i_empty) begin
						if (word_idx == LAST_IDX) begin
							word_idx <= '0;
							state    <= ST_ISSUE;
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end
				ST_ISSUE: begin
					o_cmd_valid <= 1'b1;
					state       <= ST_WAIT;
				end
				ST_WAIT: begin
					if (i_engine_done)
						state <= ST_COLLECT;  // engine free, fetch the next one
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (o_rd_en)
			cmd_words[word_idx] <= i_rd_data;
	end

	// unpack by the word format, held until the next issue
	always_ff @(posedge okClk) begin
		if (state == ST_ISSUE) begin
			o_cmd.op          <= op_e'(cmd_words[0][2:0]);
			o_cmd.padding     <= cmd_words[0][3];
			o_cmd.stride      <= cmd_words[0][7:4];
			o_cmd.kernel      <= cmd_words[0][15:8];
			o_cmd.i_side      <= cmd_words[0][23:16];
			o_cmd.o_side      <= cmd_words[0][31:24];
			o_cmd.i_channel   <= cmd_words[1][15:0];
			o_cmd.o_channel   <= cmd_words[1][31:16];
			o_cmd.data_addr   <= cmd_words[2];
			o_cmd.weight_addr <= cmd_words[3];
		end
	end

	// ----------------------------------------------------------------------
	// completion count and interrupt
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			done_cnt <= '0;
			o_irq    <= 1'b0;
		end else if (!i_op_en) begin
			done_cnt <= '0;  // new operation starts from zero
			o_irq    <= 1'b0;
		end else begin
			if (state == ST_WAIT && i_engine_done)
				done_cnt <= done_cnt + 1'b1;
			if (i_cmd_count != '0 && done_cnt == i_cmd_count)
				o_irq <= 1'b1;  // level, held until op_en drops
		end
	end

	a_valid_pulse : assert property (
		@(posedge okClk) disable iff (!i_arst_n)
		o_cmd_valid |=> !o_cmd_valid
	);

	// host must only send the four defined layer types
	a_legal_op : assert property (
		@(posedge okClk) disable iff (!i_arst_n)
		o_cmd_valid |-> (o_cmd.op inside {OP_CONV3X3, OP_CONV1X1, OP_MAXPOOL, OP_AVEPOOL})
	);

endmodule

/* hw/cmd_path_top.sv */
`timescale 1ns/1ns

module cmd_path_top
	import cmd_pkg::*;
#(
	parameter int DEPTH       = 64,  // FIFO words, power of two
	parameter int BLOCK_WORDS = 16,  // host block length
	parameter int HEADROOM    = 4    // count latency margin
) (
	input  logic              okClk,
	input  logic              i_arst_n,
	input  logic              i_pipe_write,
	input  logic [WORD_W-1:0] i_pipe_data,
	input  logic              i_op_en,
	input  logic [7:0]        i_cmd_count,
	input  logic              i_engine_done,
	output logic              o_pipe_ready,
	output logic              o_overrun,
	output cmd_t              o_cmd,
	output logic              o_cmd_valid,
	output logic              o_irq
);

	localparam int CNT_W = $clog2(DEPTH) + 1;

	logic              wr_en;
	logic [WORD_W-1:0] wr_data;
	logic [CNT_W-1:0]  fifo_count;
	logic              fifo_full;
	logic              fifo_empty;
	logic [WORD_W-1:0] rd_data;
	logic              rd_en;

	// ----------------------------------------------------------------------
	// host write path, word buffer, command parser
	// ----------------------------------------------------------------------
	pipe_in_gate #(
		.DEPTH       (DEPTH),
		.BLOCK_WORDS (BLOCK_WORDS),
		.HEADROOM    (HEADROOM)
	) u_pipe_in_gate (
		.okClk        (okClk),
		.i_arst_n     (i_arst_n),
		.i_pipe_write (i_pipe_write),
		.i_pipe_data  (i_pipe_data),
		.i_fifo_count (fifo_count),
		.i_fifo_full  (fifo_full),
		.o_wr_en      (wr_en),
		.o_wr_data    (wr_data),
		.o_pipe_ready (o_pipe_ready),
		.o_overrun    (o_overrun)
	);

	word_fifo #(
		.DEPTH (DEPTH)
	) u_word_fifo (
		.okClk     (okClk),
		.i_arst_n  (i_arst_n),
		.i_wr_en   (wr_en),
		.i_wr_data (wr_data),
		.i_rd_en   (rd_en),
		.o_rd_data (rd_data),
		.o_empty   (fifo_empty),
		.o_full    (fifo_full),
		.o_count   (fifo_count)
	);

	cmd_parser u_cmd_parser (
		.okClk         (okClk),
		.i_arst_n      (i_arst_n),
		.i_op_en       (i_op_en),
		.i_cmd_count   (i_cmd_count),
		.i_rd_data     (rd_data),
		.i_empty       (fifo_empty),
		.i_engine_done (i_engine_done),
		.o_rd_en       (rd_en),
		.o_cmd         (o_cmd),
		.o_cmd_valid   (o_cmd_valid),
		.o_irq         (o_irq)
	);

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD_NS   = 100,
	parameter int RESET_CYCLES = 10
) (
	input  logic i_restart,   // pulse to reset the DUT again
	output logic o_clk,
	output logic o_arst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	initial begin
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_arst_n <= 1'b1;
		forever begin
			@(posedge i_restart);
			o_arst_n <= 1'b0;
			repeat (RESET_CYCLES) @(posedge o_clk);
			o_arst_n <= 1'b1;
		end
	end

endmodule

/* verif/cmd_path_tb.sv */
`timescale 1ns/1ns

module cmd_path_tb
	import cmd_pkg::*;
;

	localparam int DEPTH       = 64;
	localparam int BLOCK_WORDS = 16;
	// worst case cycles of the reset, single, multi, throttle, back pressure and overrun tests
	localparam int WORST_CYCLES = 40 + 80 + 5 * 30 + 80 + 12 * 30 + 100 + 20 * 50 + 150 + 120;
	localparam int WATCHDOG_NS  = WORST_CYCLES * 2 * 100;

	logic              okClk;
	logic              i_arst_n;
	logic              restart;
	logic              i_pipe_write;
	logic [WORD_W-1:0] i_pipe_data;
	logic              i_op_en;
	logic [7:0]        i_cmd_count;
	logic              i_engine_done;
	logic              o_pipe_ready;
	logic              o_overrun;
	cmd_t              o_cmd;
	logic              o_cmd_valid;
	logic              o_irq;

	logic [31:0]       lcg_state = 32'd37;
	logic [WORD_W-1:0] word_q[$];   // words still to be written by the host
	logic [127:0]      exp_q[$];    // expected commands packed from word 3 down to word 0
	int                eng_wait = 0;
	int                extra_delay = 0;
	int                done_seen = 0;

	tb_clock u_clock (.i_restart(restart), .o_clk(okClk), .o_arst_n(i_arst_n));

	cmd_path_top #(.DEPTH(DEPTH), .BLOCK_WORDS(BLOCK_WORDS), .HEADROOM(4)) i_dut (.*);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic fail_run(input string why);
		$display("%s at %0t", why, $time);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s: got %0h expected %0h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// ----------------------------------------------------------------------
	// engine stand-in and command monitor
	// ----------------------------------------------------------------------
	always @(posedge okClk) begin
		i_engine_done <= 1'b0;
		if (!i_op_en)
			done_seen = 0;
		if (o_cmd_valid) begin
			eng_wait = int'(lcg_next() % 8) + 1 + extra_delay;
		end else if (eng_wait > 0) begin
			eng_wait--;
			if (eng_wait == 0) begin
				i_engine_done <= 1'b1;
				done_seen++;
			end
		end
	end

	always @(posedge okClk) begin
		logic [127:0] w;
		if (o_cmd_valid) begin
			if (exp_q.size() == 0)
				fail_run("a command was issued when none was expected");
			w = exp_q.pop_front();
			check("o_cmd.op", o_cmd.op, w[2:0]);
			check("o_cmd.padding", o_cmd.padding, w[3]);
			check("o_cmd.stride", o_cmd.stride, w[7:4]);
			check("o_cmd.kernel", o_cmd.kernel, w[15:8]);
			check("o_cmd.i_side", o_cmd.i_side, w[23:16]);
			check("o_cmd.o_side", o_cmd.o_side, w[31:24]);
			check("o_cmd.i_channel", o_cmd.i_channel, w[47:32]);
			check("o_cmd.o_channel", o_cmd.o_channel, w[63:48]);
			check("o_cmd.data_addr", o_cmd.data_addr, w[95:64]);
			check("o_cmd.weight_addr", o_cmd.weight_addr, w[127:96]);
		end
		if (o_irq && i_op_en && done_seen < int'(i_cmd_count))
			fail_run("interrupt rose before all commands were done");
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout, the tests did not finish in time");
	end

	// ----------------------------------------------------------------------
	// host helpers
	// ----------------------------------------------------------------------
	task automatic queue_cmd();
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w3;
		w0 = lcg_next();
		w0[2] = 1'b0;  // legal op only
		w1 = lcg_next();
		w2 = lcg_next();
		w3 = lcg_next();
		word_q.push_back(w0);
		word_q.push_back(w1);
		word_q.push_back(w2);
		word_q.push_back(w3);
		exp_q.push_back({w3, w2, w1, w0});
	endtask

	task automatic send_words(input bit honor_ready);
		int n;
		while (word_q.size() > 0) begin
			while (honor_ready && !o_pipe_ready)
				@(posedge okClk);
			n = (word_q.size() < BLOCK_WORDS) ? word_q.size() : BLOCK_WORDS;
			repeat (n) begin
				@(posedge okClk);
				i_pipe_write <= 1'b1;
				i_pipe_data  <= word_q.pop_front();
			end
			@(posedge okClk);
			i_pipe_write <= 1'b0;
		end
	endtask

	task automatic wait_irq(input int max_cycles);
		int n;
		n = 0;
		while (!o_irq) begin
			@(posedge okClk);
			n++;
			if (n > max_cycles)
				fail_run("interrupt did not rise in time");
		end
		check("exp_q.size", exp_q.size(), 0);
	endtask

	task automatic end_op();
		@(posedge okClk);
		i_op_en <= 1'b0;
		repeat (2) @(posedge okClk);
		check("o_irq", o_irq, 1'b0);
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_reset();
		repeat (2) @(posedge okClk);
		check("o_cmd_valid", o_cmd_valid, 1'b0);
		check("o_irq", o_irq, 1'b0);
		check("o_overrun", o_overrun, 1'b0);
		@(posedge i_arst_n);
		repeat (2) @(posedge okClk);
		check("o_pipe_ready", o_pipe_ready, 1'b1);
	endtask

	task automatic test_single_cmd();
		queue_cmd();
		send_words(1'b1);
		@(posedge okClk);
		i_cmd_count <= 8'd1;
		i_op_en     <= 1'b1;
		wait_irq(60);
		end_op();
	endtask

	task automatic test_multi_cmd();
		repeat (5) queue_cmd();
		send_words(1'b1);
		@(posedge okClk);
		i_cmd_count <= 8'd5;
		i_op_en     <= 1'b1;
		wait_irq(5 * 30);
		end_op();
	endtask

	task automatic test_throttle();
		repeat (12) queue_cmd();  // 48 words, three blocks
		send_words(1'b1);
		repeat (2) @(posedge okClk);
		check("o_pipe_ready", o_pipe_ready, 1'b0);
		check("o_overrun", o_overrun, 1'b0);
		i_cmd_count <= 8'd12;
		i_op_en     <= 1'b1;
		wait_irq(12 * 30);
		check("o_pipe_ready", o_pipe_ready, 1'b1);
		end_op();
	endtask

	task automatic test_back_pressure();
		extra_delay = 30;
		repeat (20) queue_cmd();
		@(posedge okClk);
		i_cmd_count <= 8'd20;
		i_op_en     <= 1'b1;
		send_words(1'b1);
		wait_irq(20 * 50);
		check("o_overrun", o_overrun, 1'b0);
		end_op();
		extra_delay = 0;
	endtask

	task automatic test_overrun();
		repeat (DEPTH + 1) word_q.push_back(lcg_next());
		send_words(1'b0);
		repeat (2) @(posedge okClk);
		check("o_overrun", o_overrun, 1'b1);
		repeat (10) @(posedge okClk);
		check("o_overrun", o_overrun, 1'b1);  // sticky
		restart <= 1'b1;
		@(posedge okClk);
		restart <= 1'b0;
		@(posedge i_arst_n);
		repeat (2) @(posedge okClk);
		check("o_overrun", o_overrun, 1'b0);
	endtask

	initial begin
		restart       = 1'b0;
		i_pipe_write  = 1'b0;
		i_pipe_data   = '0;
		i_op_en       = 1'b0;
		i_cmd_count   = '0;
		i_engine_done = 1'b0;
		test_reset();
		test_single_cmd();
		test_multi_cmd();
		test_throttle();
		test_back_pressure();
		test_overrun();
		if (exp_q.size() != 0) begin
			fail_run("expected commands were never issued");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

/* cmd_path_top.f */
hw/cmd_pkg.sv
hw/pipe_in_gate.sv
hw/word_fifo.sv
hw/cmd_parser.sv
hw/cmd_path_top.sv
verif/tb_clock.sv
verif/cmd_path_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= cmd_path_top.f
TB_TOP    ?= cmd_path_tb
RTL_TOP   ?= cmd_path_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
